// File: include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath and register-address widths
`define NB_DATA    32
`define NB_ADDR    5

// memory depths in 32-bit words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// forwarding select width
`define NB_FW      2

`endif

// File: hdl/isa_pkg.sv
`include "mips_macros.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        RTYPE = 6'd0,
        J     = 6'd2,
        BEQ   = 6'd4,
        ADDIU = 6'd9,
        LW    = 6'd35,
        SW    = 6'd43
    } opcode_e;

    // funct field, R-type only
    typedef enum logic [5:0] {
        ADDU = 6'd33,
        SUBU = 6'd35,
        AND  = 6'd36,
        OR   = 6'd37,
        SLT  = 6'd42
    } funct_e;

    typedef struct packed {
        opcode_e             opcode;
        logic [`NB_ADDR-1:0] rs;
        logic [`NB_ADDR-1:0] rt;
        logic [`NB_ADDR-1:0] rd;
        logic [4:0]          shamt;
        funct_e              funct;
    } rType_t;

    typedef struct packed {
        opcode_e             opcode;
        logic [`NB_ADDR-1:0] rs;
        logic [`NB_ADDR-1:0] rt;
        logic [15:0]         immediate;
    } iType_t;

    // one instruction word, two decodings
    typedef union packed {
        rType_t r;
        iType_t i;
    } instr_u;

    typedef logic [25:0] jTarget_t;   // low 26 bits of the I-type view

endpackage

// File: hdl/pipe_pkg.sv
`include "mips_macros.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT
    } aluOp_e;

    // built in ID, travels down to WB
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   mem2reg;     // write-back takes memory data
        logic   regDst;      // rd instead of rt
        logic   aluSrcImm;
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [`NB_ADDR-1:0] rs;
        logic [`NB_ADDR-1:0] rt;
        logic [`NB_ADDR-1:0] rd;
        logic [`NB_DATA-1:0] regA;
        logic [`NB_DATA-1:0] regB;
        logic [`NB_DATA-1:0] immediate;   // sign extended
    } idEx_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [`NB_ADDR-1:0] writeReg;
        logic [`NB_DATA-1:0] aluResult;
        logic [`NB_DATA-1:0] data4Mem;
    } exMem_t;

    typedef struct packed {
        logic                regWrite;
        logic [`NB_ADDR-1:0] reg2write;
        logic [`NB_DATA-1:0] writeData;
    } wb_t;

    typedef struct packed {
        logic                                valid;
        logic [$clog2(`DMEM_DEPTH)+1:0]      dataAddr;   // byte address
        logic [`NB_DATA-1:0]                 data2mem;
    } store_t;

    typedef enum logic [`NB_FW-1:0] {
        REG,
        MEMWB,
        EXMEM
    } fwSel_e;

endpackage

// File: hdl/instruction_fetch.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module instruction_fetch (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_weIF,
    input  logic [`NB_DATA-1:0] i_instrData,
    input  logic                i_halt,
    input  logic                i_stall,
    input  logic                i_takeJump,
    input  logic [`NB_DATA-1:0] i_addr2jump,
    output logic [`NB_DATA-1:0] o_instruction,
    output logic [`NB_DATA-1:0] o_pcounter4
);
    localparam int NB_IDX = $clog2(`IMEM_DEPTH);

    logic [`NB_DATA-1:0] instrMem [`IMEM_DEPTH];
    logic [`NB_DATA-1:0] pc;
    logic [`NB_DATA-1:0] pc4;
    logic [NB_IDX:0]     loadPtr;     // extra bit so a full memory still counts
    logic [`NB_DATA-1:0] loadBytes;
    logic [`NB_DATA-1:0] fetchWord;

    assign pc4       = pc + 32'd4;
    assign loadBytes = {{(`NB_DATA-NB_IDX-3){1'b0}}, loadPtr, 2'b00};
    // nothing loaded there, hand out a nop
    assign fetchWord = (pc < loadBytes) ? instrMem[pc[NB_IDX+1:2]] : '0;

    always_ff @(posedge clk) begin
        if (i_halt && i_weIF) begin
            instrMem[loadPtr[NB_IDX-1:0]] <= i_instrData;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            pc            <= '0;
            loadPtr       <= '0;
            o_instruction <= '0;
            o_pcounter4   <= '0;
        end else if (i_halt) begin
            if (i_weIF) begin
                loadPtr <= loadPtr + {{NB_IDX{1'b0}}, 1'b1};
            end
        end else if (!i_stall) begin
            if (i_takeJump) begin
                pc            <= i_addr2jump;
                o_instruction <= '0;   // squash the word behind BEQ/J
                o_pcounter4   <= '0;
            end else begin
                pc            <= pc4;
                o_instruction <= fetchWord;
                o_pcounter4   <= pc4;
            end
        end
    end

    // program load only with the core halted
    assert property (@(posedge clk) disable iff (!i_rstN) i_weIF |-> i_halt)
        else $error("instruction memory written while running");

endmodule

// File: hdl/instruction_decode.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module instruction_decode (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_halt,
    input  logic                i_stall,
    input  isa_pkg::instr_u     i_instruction,
    input  logic [`NB_DATA-1:0] i_pcounter4,
    input  pipe_pkg::wb_t       i_wb,
    input  logic [`NB_DATA-1:0] i_fwdExMem,
    output pipe_pkg::idEx_t     o_idEx,
    output logic                o_takeJump,
    output logic [`NB_DATA-1:0] o_addr2jump,
    output logic [`NB_ADDR-1:0] o_rsIFID,
    output logic [`NB_ADDR-1:0] o_rtIFID
);
    logic [`NB_DATA-1:0] regFile [2**`NB_ADDR];
    pipe_pkg::ctrl_t     ctrl;
    logic [`NB_ADDR-1:0] rs;
    logic [`NB_ADDR-1:0] rt;
    logic [`NB_ADDR-1:0] fwdDest;      // mirror of the EX/MEM ALU destination
    logic [`NB_DATA-1:0] regA;
    logic [`NB_DATA-1:0] regB;
    logic [`NB_DATA-1:0] cmpA;
    logic [`NB_DATA-1:0] cmpB;
    logic [`NB_DATA-1:0] immExt;
    logic [`NB_DATA-1:0] branchTarget;
    isa_pkg::jTarget_t   jTarget;
    logic                isBeq;
    logic                isJump;

    // read with write-through from WB
    function automatic logic [`NB_DATA-1:0] readReg(input logic [`NB_ADDR-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb.regWrite && i_wb.reg2write == addr) begin
            return i_wb.writeData;
        end
        return regFile[addr];
    endfunction

    assign rs = i_instruction.i.rs;
    assign rt = i_instruction.i.rt;

    always_comb begin
        regA = readReg(rs);
        regB = readReg(rt);
    end

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            regFile[0] <= '0;
        end else if (i_wb.regWrite) begin
            regFile[i_wb.reg2write] <= i_wb.writeData;
        end
    end

    // ------------------------------------------------------------------------
    // control decode
    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = pipe_pkg::ADD;
        case (i_instruction.r.opcode)
            isa_pkg::RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (i_instruction.r.funct)
                    isa_pkg::ADDU: ctrl.aluOp = pipe_pkg::ADD;
                    isa_pkg::SUBU: ctrl.aluOp = pipe_pkg::SUB;
                    isa_pkg::AND:  ctrl.aluOp = pipe_pkg::AND;
                    isa_pkg::OR:   ctrl.aluOp = pipe_pkg::OR;
                    isa_pkg::SLT:  ctrl.aluOp = pipe_pkg::SLT;
                    default:       ctrl.regWrite = 1'b0;   // unknown funct acts as a nop
                endcase
            end
            isa_pkg::ADDIU: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            isa_pkg::LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.mem2reg   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            isa_pkg::SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            default: ;   // BEQ and J finish here
        endcase
    end

    // ------------------------------------------------------------------------
    // branch and jump resolution
    assign cmpA = (fwdDest != '0 && fwdDest == rs) ? i_fwdExMem : regA;
    assign cmpB = (fwdDest != '0 && fwdDest == rt) ? i_fwdExMem : regB;

    assign isBeq        = i_instruction.i.opcode == isa_pkg::BEQ;
    assign isJump       = i_instruction.i.opcode == isa_pkg::J;
    assign immExt       = {{16{i_instruction.i.immediate[15]}}, i_instruction.i.immediate};
    assign jTarget      = {i_instruction.i.rs, i_instruction.i.rt, i_instruction.i.immediate};
    assign branchTarget = i_pcounter4 + {immExt[`NB_DATA-3:0], 2'b00};

    assign o_takeJump  = isJump || (isBeq && cmpA == cmpB);
    assign o_addr2jump = isJump ? {i_pcounter4[`NB_DATA-1:28], jTarget, 2'b00} : branchTarget;
    assign o_rsIFID    = rs;
    assign o_rtIFID    = rt;

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            o_idEx  <= '0;
            fwdDest <= '0;
        end else if (!i_halt) begin
            o_idEx <= '{ctrl: ctrl, rs: rs, rt: rt, rd: i_instruction.r.rd,
                        regA: regA, regB: regB, immediate: immExt};
            if (i_stall) begin
                o_idEx.ctrl <= '0;   // bubble
            end
            // loads are not ready in EX/MEM
            fwdDest <= (o_idEx.ctrl.regWrite && !o_idEx.ctrl.memRead) ?
                       (o_idEx.ctrl.regDst ? o_idEx.rd : o_idEx.rt) : '0;
        end
    end

    // $zero holds across any write-back traffic
    assert property (@(posedge clk) disable iff (!i_rstN) regFile[0] == '0)
        else $error("register 0 lost its zero value");

endmodule

// File: hdl/hazard_detection_unit.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module hazard_detection_unit (
    input  logic [`NB_ADDR-1:0] i_rsIFID,
    input  logic [`NB_ADDR-1:0] i_rtIFID,
    input  pipe_pkg::idEx_t     i_idEx,
    input  logic [`NB_ADDR-1:0] i_exMemDest,
    input  logic                i_exMemLoad,
    input  logic                i_isBranch,
    output logic                o_stall
);
    logic [`NB_ADDR-1:0] exDest;
    logic                loadUse;
    logic                exBusy;
    logic                memLoadBusy;

    function automatic logic hits(input logic [`NB_ADDR-1:0] dest,
                                  input logic [`NB_ADDR-1:0] rs,
                                  input logic [`NB_ADDR-1:0] rt);
        return dest != '0 && (dest == rs || dest == rt);
    endfunction

    assign exDest      = i_idEx.ctrl.regDst ? i_idEx.rd : i_idEx.rt;
    assign loadUse     = i_idEx.ctrl.memRead && hits(i_idEx.rt, i_rsIFID, i_rtIFID);
    // BEQ compares in ID, so EX results and loads in MEM are too late
    assign exBusy      = i_idEx.ctrl.regWrite && hits(exDest, i_rsIFID, i_rtIFID);
    assign memLoadBusy = i_exMemLoad && hits(i_exMemDest, i_rsIFID, i_rtIFID);

    assign o_stall = loadUse || (i_isBranch && (exBusy || memLoadBusy));

endmodule

// File: hdl/forwarding_unit.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module forwarding_unit (
    input  logic [`NB_ADDR-1:0] i_rs,
    input  logic [`NB_ADDR-1:0] i_rt,
    input  logic [`NB_ADDR-1:0] i_exMemDest,
    input  logic                i_exMemWrite,
    input  pipe_pkg::wb_t       i_wb,
    output pipe_pkg::fwSel_e    o_fwA,
    output pipe_pkg::fwSel_e    o_fwB
);
    // newest producer wins
    function automatic pipe_pkg::fwSel_e pick(input logic [`NB_ADDR-1:0] src,
                                              input logic [`NB_ADDR-1:0] exMemDest,
                                              input logic                exMemWrite,
                                              input pipe_pkg::wb_t       wb);
        if (src == '0) begin
            return pipe_pkg::REG;
        end
        if (exMemWrite && exMemDest == src) begin
            return pipe_pkg::EXMEM;
        end
        if (wb.regWrite && wb.reg2write == src) begin
            return pipe_pkg::MEMWB;
        end
        return pipe_pkg::REG;
    endfunction

    assign o_fwA = pick(i_rs, i_exMemDest, i_exMemWrite, i_wb);
    assign o_fwB = pick(i_rt, i_exMemDest, i_exMemWrite, i_wb);

endmodule

// File: hdl/instruction_execute.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module instruction_execute (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_halt,
    input  pipe_pkg::idEx_t     i_idEx,
    input  pipe_pkg::fwSel_e    i_fwA,
    input  pipe_pkg::fwSel_e    i_fwB,
    input  logic [`NB_DATA-1:0] i_wbData,
    output pipe_pkg::exMem_t    o_exMem
);
    logic [`NB_DATA-1:0] opA;
    logic [`NB_DATA-1:0] opB;
    logic [`NB_DATA-1:0] aluB;
    logic [`NB_DATA-1:0] aluResult;

    function automatic logic [`NB_DATA-1:0] fwdMux(input pipe_pkg::fwSel_e    sel,
                                                    input logic [`NB_DATA-1:0] regVal,
                                                    input logic [`NB_DATA-1:0] exMemVal,
                                                    input logic [`NB_DATA-1:0] wbVal);
        case (sel)
            pipe_pkg::EXMEM: return exMemVal;
            pipe_pkg::MEMWB: return wbVal;
            default:         return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(i_fwA, i_idEx.regA, o_exMem.aluResult, i_wbData);
    assign opB  = fwdMux(i_fwB, i_idEx.regB, o_exMem.aluResult, i_wbData);
    assign aluB = i_idEx.ctrl.aluSrcImm ? i_idEx.immediate : opB;

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            pipe_pkg::SUB: aluResult = opA - aluB;
            pipe_pkg::AND: aluResult = opA & aluB;
            pipe_pkg::OR:  aluResult = opA | aluB;
            pipe_pkg::SLT: aluResult = {{(`NB_DATA-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default:       aluResult = opA + aluB;   // ADD, address calc
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            o_exMem <= '0;
        end else if (!i_halt) begin
            o_exMem <= '{ctrl:      i_idEx.ctrl,
                         writeReg:  i_idEx.ctrl.regDst ? i_idEx.rd : i_idEx.rt,
                         aluResult: aluResult,
                         data4Mem:  opB};   // store data after forwarding
        end
    end

endmodule

// File: hdl/memory_access.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module memory_access (
    input  logic             clk,
    input  logic             i_rstN,
    input  logic             i_halt,
    input  pipe_pkg::exMem_t i_exMem,
    output pipe_pkg::wb_t    o_wb,
    output pipe_pkg::store_t o_store
);
    localparam int NB_IDX = $clog2(`DMEM_DEPTH);

    logic [`NB_DATA-1:0] dataMem [`DMEM_DEPTH];
    logic [NB_IDX-1:0]   wordIdx;
    logic                storeNow;
    pipe_pkg::wb_t       memWb;

    assign wordIdx  = i_exMem.aluResult[NB_IDX+1:2];
    assign storeNow = i_exMem.ctrl.memWrite && !i_halt;   // once, on the cycle it leaves

    always_ff @(posedge clk) begin
        if (storeNow) begin
            dataMem[wordIdx] <= i_exMem.data4Mem;
        end
    end

    // ------------------------------------------------------------------------
    // MEM/WB with the write-back select in front
    always_ff @(posedge clk) begin
        if (!i_rstN) begin
            memWb <= '0;
        end else if (!i_halt) begin
            memWb.regWrite  <= i_exMem.ctrl.regWrite && i_exMem.writeReg != '0;
            memWb.reg2write <= i_exMem.writeReg;
            memWb.writeData <= i_exMem.ctrl.mem2reg ? dataMem[wordIdx] : i_exMem.aluResult;
        end
    end

    // a held MEM/WB is reported when halt drops
    always_comb begin
        o_wb          = memWb;
        o_wb.regWrite = memWb.regWrite && !i_halt;
    end

    assign o_store = '{valid:    storeNow,
                       dataAddr: i_exMem.aluResult[NB_IDX+1:0],
                       data2mem: i_exMem.data4Mem};

endmodule

// File: hdl/pipeline.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module pipeline (
    input  logic                clk,
    input  logic                i_rstN,
    input  logic                i_weIF,
    input  logic [`NB_DATA-1:0] i_instrData,
    input  logic                i_halt,
    output pipe_pkg::wb_t       o_wb,
    output pipe_pkg::store_t    o_store
);
    isa_pkg::instr_u     instrIFID;
    logic [`NB_DATA-1:0] pc4IFID;
    logic [`NB_DATA-1:0] addr2jump;
    logic                takeJump;
    logic                stall;
    logic                isBranch;
    logic [`NB_ADDR-1:0] rsIFID;
    logic [`NB_ADDR-1:0] rtIFID;
    pipe_pkg::idEx_t     idEx;
    pipe_pkg::exMem_t    exMem;
    pipe_pkg::fwSel_e    fwA;
    pipe_pkg::fwSel_e    fwB;

    assign isBranch = instrIFID.i.opcode == isa_pkg::BEQ;   // only BEQ reads regs in ID

    // ------------------------------------------------------------------------
    // stages
    instruction_fetch if_inst (
        .clk           (clk        ),
        .i_rstN        (i_rstN     ),
        .i_weIF        (i_weIF     ),
        .i_instrData   (i_instrData),
        .i_halt        (i_halt     ),
        .i_stall       (stall      ),
        .i_takeJump    (takeJump   ),
        .i_addr2jump   (addr2jump  ),
        .o_instruction (instrIFID  ),
        .o_pcounter4   (pc4IFID    )
    );

    instruction_decode id_inst (
        .clk           (clk              ),
        .i_rstN        (i_rstN           ),
        .i_halt        (i_halt           ),
        .i_stall       (stall            ),
        .i_instruction (instrIFID        ),
        .i_pcounter4   (pc4IFID          ),
        .i_wb          (o_wb             ),
        .i_fwdExMem    (exMem.aluResult  ),
        .o_idEx        (idEx             ),
        .o_takeJump    (takeJump         ),
        .o_addr2jump   (addr2jump        ),
        .o_rsIFID      (rsIFID           ),
        .o_rtIFID      (rtIFID           )
    );

    instruction_execute exe_inst (
        .clk      (clk           ),
        .i_rstN   (i_rstN        ),
        .i_halt   (i_halt        ),
        .i_idEx   (idEx          ),
        .i_fwA    (fwA           ),
        .i_fwB    (fwB           ),
        .i_wbData (o_wb.writeData),
        .o_exMem  (exMem         )
    );

    memory_access mem_inst (
        .clk     (clk    ),
        .i_rstN  (i_rstN ),
        .i_halt  (i_halt ),
        .i_exMem (exMem  ),
        .o_wb    (o_wb   ),
        .o_store (o_store)
    );

    // ------------------------------------------------------------------------
    // hazard and forwarding
    hazard_detection_unit hdu_inst (
        .i_rsIFID    (rsIFID              ),
        .i_rtIFID    (rtIFID              ),
        .i_idEx      (idEx                ),
        .i_exMemDest (exMem.writeReg      ),
        .i_exMemLoad (exMem.ctrl.memRead  ),
        .i_isBranch  (isBranch            ),
        .o_stall     (stall               )
    );

    forwarding_unit fu_inst (
        .i_rs         (idEx.rs             ),
        .i_rt         (idEx.rt             ),
        .i_exMemDest  (exMem.writeReg      ),
        .i_exMemWrite (exMem.ctrl.regWrite ),
        .i_wb         (o_wb                ),
        .o_fwA        (fwA                 ),
        .o_fwB        (fwB                 )
    );

endmodule

// File: verif/tb_pipeline.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module tb_pipeline;

    localparam int PROG_LEN   = 27;
    localparam int NUM_EVENTS = 17;
    localparam int MAX_CYCLES = 8 * PROG_LEN + 40;
    localparam int HALT_AT    = 14;    // run cycle where halt goes high
    localparam int HALT_LEN   = 5;
    localparam int DRAIN      = 12;    // quiet cycles after the last event
    localparam int NB_DADDR   = $clog2(`DMEM_DEPTH) + 2;

    // one expected write-back or store, in program order
    typedef struct packed {
        logic             isStore;
        pipe_pkg::wb_t    wb;
        pipe_pkg::store_t store;
    } event_t;

    logic                clk;
    logic                rstN;
    logic                weIF;
    logic [`NB_DATA-1:0] instrData;
    logic                halt;
    pipe_pkg::wb_t       wbOut;
    pipe_pkg::store_t    storeOut;

    isa_pkg::instr_u progWords [PROG_LEN];
    event_t          expected  [NUM_EVENTS];
    int              valueErrors = 0;
    int              eventErrors = 0;
    int              nextEv      = 0;

    pipeline u_dut (
        .clk         (clk      ),
        .i_rstN      (rstN     ),
        .i_weIF      (weIF     ),
        .i_instrData (instrData),
        .i_halt      (halt     ),
        .o_wb        (wbOut    ),
        .o_store     (storeOut )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // instruction and event builders
    function automatic isa_pkg::instr_u rInstr(input isa_pkg::funct_e     funct,
                                               input logic [`NB_ADDR-1:0] rd,
                                               input logic [`NB_ADDR-1:0] rs,
                                               input logic [`NB_ADDR-1:0] rt);
        isa_pkg::instr_u w;
        w.r = '{opcode: isa_pkg::RTYPE, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: funct};
        return w;
    endfunction

    function automatic isa_pkg::instr_u immInstr(input isa_pkg::opcode_e    op,
                                                 input logic [`NB_ADDR-1:0] rs,
                                                 input logic [`NB_ADDR-1:0] rt,
                                                 input logic [15:0]         imm);
        isa_pkg::instr_u w;
        w.i = '{opcode: op, rs: rs, rt: rt, immediate: imm};
        return w;
    endfunction

    function automatic isa_pkg::instr_u jumpInstr(input isa_pkg::jTarget_t target);
        isa_pkg::instr_u w;
        w.i.opcode    = isa_pkg::J;
        w.i.rs        = target[25:21];
        w.i.rt        = target[20:16];
        w.i.immediate = target[15:0];
        return w;
    endfunction

    function automatic event_t wbEvent(input logic [`NB_ADDR-1:0] dest,
                                       input logic [`NB_DATA-1:0] data);
        event_t ev;
        ev    = '0;
        ev.wb = '{regWrite: 1'b1, reg2write: dest, writeData: data};
        return ev;
    endfunction

    function automatic event_t storeEvent(input logic [NB_DADDR-1:0] addr,
                                          input logic [`NB_DATA-1:0] data);
        event_t ev;
        ev         = '0;
        ev.isStore = 1'b1;
        ev.store   = '{valid: 1'b1, dataAddr: addr, data2mem: data};
        return ev;
    endfunction

    task automatic fillTables();
        progWords[0]  = immInstr(isa_pkg::ADDIU, 5'd0, 5'd1, 16'd12);      // addiu r1, r0, 12
        progWords[1]  = immInstr(isa_pkg::ADDIU, 5'd0, 5'd2, 16'hfffd);    // addiu r2, r0, -3
        progWords[2]  = rInstr(isa_pkg::ADDU, 5'd3, 5'd1, 5'd2);
        progWords[3]  = rInstr(isa_pkg::SUBU, 5'd4, 5'd3, 5'd1);
        progWords[4]  = rInstr(isa_pkg::SLT, 5'd5, 5'd4, 5'd1);            // -3 < 12
        progWords[5]  = rInstr(isa_pkg::SLT, 5'd6, 5'd1, 5'd4);
        progWords[6]  = rInstr(isa_pkg::AND, 5'd7, 5'd1, 5'd3);
        progWords[7]  = rInstr(isa_pkg::OR, 5'd8, 5'd3, 5'd1);
        progWords[8]  = immInstr(isa_pkg::ADDIU, 5'd1, 5'd0, 16'd7);       // lost in r0
        progWords[9]  = rInstr(isa_pkg::ADDU, 5'd9, 5'd0, 5'd1);
        progWords[10] = immInstr(isa_pkg::SW, 5'd1, 5'd8, 16'd4);          // sw r8, 4(r1)
        progWords[11] = immInstr(isa_pkg::LW, 5'd0, 5'd10, 16'd16);        // lw r10, 16(r0)
        progWords[12] = rInstr(isa_pkg::SUBU, 5'd11, 5'd10, 5'd5);         // load-use
        progWords[13] = immInstr(isa_pkg::BEQ, 5'd11, 5'd1, 16'd2);        // taken, to 16
        progWords[14] = immInstr(isa_pkg::ADDIU, 5'd0, 5'd12, 16'd111);
        progWords[15] = immInstr(isa_pkg::ADDIU, 5'd0, 5'd12, 16'd222);
        progWords[16] = immInstr(isa_pkg::BEQ, 5'd1, 5'd2, 16'd1);         // falls through
        progWords[17] = immInstr(isa_pkg::ADDIU, 5'd0, 5'd13, 16'h7fff);
        progWords[18] = jumpInstr(26'd21);
        progWords[19] = immInstr(isa_pkg::ADDIU, 5'd0, 5'd14, 16'd1);
        progWords[20] = immInstr(isa_pkg::ADDIU, 5'd0, 5'd14, 16'd2);
        progWords[21] = immInstr(isa_pkg::LW, 5'd0, 5'd15, 16'd16);
        progWords[22] = immInstr(isa_pkg::BEQ, 5'd15, 5'd8, 16'd1);        // waits on the load
        progWords[23] = immInstr(isa_pkg::ADDIU, 5'd0, 5'd16, 16'd9);
        progWords[24] = rInstr(isa_pkg::SLT, 5'd16, 5'd4, 5'd15);
        progWords[25] = immInstr(isa_pkg::SW, 5'd0, 5'd16, 16'd0);         // sw r16, 0(r0)
        progWords[26] = immInstr(isa_pkg::ADDIU, 5'd16, 5'd17, 16'hfffe);

        expected[0]  = wbEvent(5'd1, 32'h0000_000c);
        expected[1]  = wbEvent(5'd2, 32'hffff_fffd);
        expected[2]  = wbEvent(5'd3, 32'h0000_0009);
        expected[3]  = wbEvent(5'd4, 32'hffff_fffd);
        expected[4]  = wbEvent(5'd5, 32'h0000_0001);
        expected[5]  = wbEvent(5'd6, 32'h0000_0000);
        expected[6]  = wbEvent(5'd7, 32'h0000_0008);
        expected[7]  = wbEvent(5'd8, 32'h0000_000d);
        expected[8]  = wbEvent(5'd9, 32'h0000_000c);
        expected[9]  = storeEvent(8'd16, 32'h0000_000d);
        expected[10] = wbEvent(5'd10, 32'h0000_000d);
        expected[11] = wbEvent(5'd11, 32'h0000_000c);
        expected[12] = wbEvent(5'd13, 32'h0000_7fff);
        expected[13] = wbEvent(5'd15, 32'h0000_000d);
        expected[14] = wbEvent(5'd16, 32'h0000_0001);
        expected[15] = storeEvent(8'd0, 32'h0000_0001);
        expected[16] = wbEvent(5'd17, 32'hffff_ffff);
    endtask

    // ------------------------------------------------------------------------
    // checks
    task automatic checkWb(input pipe_pkg::wb_t act, input pipe_pkg::wb_t exp);
        if (act.reg2write !== exp.reg2write) begin
            $display("FAILED at %0t: o_wb.reg2write expected %0d, got %0d",
                     $time, exp.reg2write, act.reg2write);
            valueErrors++;
        end
        if (act.writeData !== exp.writeData) begin
            $display("FAILED at %0t: o_wb.writeData expected 0x%08h, got 0x%08h",
                     $time, exp.writeData, act.writeData);
            valueErrors++;
        end
    endtask

    task automatic checkStore(input pipe_pkg::store_t act, input pipe_pkg::store_t exp);
        if (act.dataAddr !== exp.dataAddr) begin
            $display("FAILED at %0t: o_store.dataAddr expected %0d, got %0d",
                     $time, exp.dataAddr, act.dataAddr);
            valueErrors++;
        end
        if (act.data2mem !== exp.data2mem) begin
            $display("FAILED at %0t: o_store.data2mem expected 0x%08h, got 0x%08h",
                     $time, exp.data2mem, act.data2mem);
            valueErrors++;
        end
    endtask

    task automatic expectQuiet(input string phase);
        if (wbOut.regWrite || storeOut.valid) begin
            $display("at %0t a write-back or store showed up while %s", $time, phase);
            eventErrors++;
        end
    endtask

    // the write-back is older than a store seen in the same cycle
    task automatic matchEvents();
        if (wbOut.regWrite) begin
            if (nextEv >= NUM_EVENTS) begin
                $display("at %0t an extra write-back to r%0d appeared", $time, wbOut.reg2write);
                eventErrors++;
            end else if (expected[nextEv].isStore) begin
                $display("at %0t a write-back to r%0d came where a store was due",
                         $time, wbOut.reg2write);
                eventErrors++;
            end else begin
                checkWb(wbOut, expected[nextEv].wb);
            end
            nextEv++;
        end
        if (storeOut.valid) begin
            if (nextEv >= NUM_EVENTS) begin
                $display("at %0t an extra store to %0d appeared", $time, storeOut.dataAddr);
                eventErrors++;
            end else if (!expected[nextEv].isStore) begin
                $display("at %0t a store to %0d came where a write-back was due",
                         $time, storeOut.dataAddr);
                eventErrors++;
            end else begin
                checkStore(storeOut, expected[nextEv].store);
            end
            nextEv++;
        end
    endtask

    // ------------------------------------------------------------------------
    initial begin
        int cycle;
        rstN      = 1'b0;
        weIF      = 1'b0;
        instrData = '0;
        halt      = 1'b1;
        fillTables();
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;

        for (int k = 0; k < PROG_LEN; k++) begin
            weIF      = 1'b1;
            instrData = progWords[k];
            @(negedge clk);
            expectQuiet("loading the program");
            @(posedge clk);
            #1;
        end
        weIF      = 1'b0;
        instrData = '0;
        @(negedge clk);
        expectQuiet("halted after the load");
        @(posedge clk);
        #1;
        halt = 1'b0;

        cycle = 0;
        while (nextEv < NUM_EVENTS && cycle < MAX_CYCLES) begin
            @(negedge clk);
            if (halt) begin
                expectQuiet("halted mid-program");
            end else begin
                matchEvents();
            end
            @(posedge clk);
            #1;
            cycle++;
            halt = (cycle >= HALT_AT) && (cycle < HALT_AT + HALT_LEN);   // pause window
        end
        if (nextEv < NUM_EVENTS) begin
            $display("timeout after %0d cycles, only %0d of %0d events appeared",
                     cycle, nextEv, NUM_EVENTS);
            eventErrors++;
        end

        halt = 1'b0;
        repeat (DRAIN) begin
            @(negedge clk);
            matchEvents();   // anything now is extra
            @(posedge clk);
            #1;
        end

        $display("errors: %0d wrong values, %0d missing or extra events",
                 valueErrors, eventErrors);
        if (valueErrors == 0 && eventErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/instruction_fetch.sv
hdl/instruction_decode.sv
hdl/hazard_detection_unit.sv
hdl/forwarding_unit.sv
hdl/instruction_execute.sv
hdl/memory_access.sv
hdl/pipeline.sv
verif/tb_pipeline.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || { echo "cannot enter the project root"; exit 1; }

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        -f all.f --top-module tb_pipeline -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_pipeline)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1
